/* hw/tlp_cfg_pkg.sv */
/*
 * Configuration constants for the TLP receive path.
 * Holds bus and header widths, counter width and the register map.
 */
package tlp_cfg_pkg;

    // Full data bus width of one beat
    localparam int TDATA_WIDTH = 128;

    // An inband header always fills exactly one half of a beat
    localparam int HDR_WIDTH = 64;
    localparam int HALF_WIDTH = TDATA_WIDTH / 2;

    // Statistics counters saturate at the top of this width
    localparam int CNT_WIDTH = 16;

    // ==========================================================
    // Register map
    // ==========================================================
    localparam int REG_ADDR_WIDTH = 2;

    localparam logic [REG_ADDR_WIDTH-1:0] REG_HDR_COUNT = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_DATA_COUNT = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_ERR_COUNT = 2'd2;

endpackage

/* hw/tlp_types_pkg.sv */
/*
 * Types for the TLP receive path.
 * Opcode and framing state enums plus the packed structs carried
 * on the input, header and data streams.
 */
package tlp_types_pkg;

    // Format/type byte of the TLP header
    typedef enum logic [7:0] {
        OP_MRD  = 8'h00,
        OP_MWR  = 8'h40,
        OP_CPL  = 8'h0A,
        OP_CPLD = 8'h4A
    } tlp_opcode_e;

    // Framing tracker state, which says whether the next beat opens a packet
    typedef enum logic {
        EXPECT_SOP = 1'b0,
        IN_PACKET  = 1'b1
    } frame_state_e;

    // Inband header, 64 bits, opcode in the top byte
    typedef struct packed {
        tlp_opcode_e  opcode;
        logic [9:0]   length_dw;
        logic [7:0]   tag;
        logic [15:0]  requester_id;
        logic [21:0]  addr_lo;
    } tlp_hdr_t;

    // One beat on the incoming TLP stream
    typedef struct packed {
        logic [tlp_cfg_pkg::TDATA_WIDTH-1:0] data;
        logic                                sop;
        logic                                last;
        logic                                dm_mode;
    } rx_beat_t;

    // One entry on the header stream, with the PU/DM mode flag alongside
    typedef struct packed {
        tlp_hdr_t hdr;
        logic     dm_mode;
    } hdr_beat_t;

    // One realigned beat on the data stream
    typedef struct packed {
        logic [tlp_cfg_pkg::TDATA_WIDTH-1:0] data;
        logic                                last;
    } data_beat_t;

endpackage

/* hw/stream_buffer.sv */
/*
 * Valid/ready buffer stage with one cycle of latency.
 * SKID = 1 gives a two-entry skid buffer with a registered ready,
 * SKID = 0 gives a single pipeline register.
 */
module stream_buffer #(
    parameter bit  SKID = 1'b1,
    parameter type T    = logic
) (
    input  logic clk,
    input  logic reset_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    generate
        if (SKID)
        begin : g_skid
            // Ready is a flop, so a beat that arrives while the output
            // stalls has to park in the second entry
            logic in_ready_q;
            T     skid_data;
            logic load_out_from_in;
            logic load_out_from_skid;
            logic load_skid;

            assign in_ready = in_ready_q;

            assign load_out_from_in = in_ready_q && in_valid && (!out_valid || out_ready);
            assign load_skid = in_ready_q && in_valid && out_valid && !out_ready;
            // While ready is low the output entry always holds a beat
            assign load_out_from_skid = !in_ready_q && out_ready;

            always_ff @(posedge clk)
            begin
                if (reset_n)
                begin
                    out_valid <= 1'b0;
                    in_ready_q <= 1'b1;
                end
                else if (in_ready_q)
                begin
                    if (!out_valid || out_ready)
                        out_valid <= in_valid;
                    else if (in_valid)
                        in_ready_q <= 1'b0;
                end
                else if (out_ready)
                begin
                    // Skid entry drains into the output, so reopen the input
                    in_ready_q <= 1'b1;
                end
            end

            always_ff @(posedge clk)
            begin
                if (load_out_from_in)
                    out_data <= in_data;
                else if (load_out_from_skid)
                    out_data <= skid_data;

                if (load_skid)
                    skid_data <= in_data;
            end
        end
        else
        begin : g_reg
            // Plain register, ready passes straight back when the slot frees up
            assign in_ready = !out_valid || out_ready;

            always_ff @(posedge clk)
            begin
                if (reset_n)
                    out_valid <= 1'b0;
                else if (in_ready)
                    out_valid <= in_valid;
            end

            always_ff @(posedge clk)
            begin
                if (in_ready && in_valid)
                    out_data <= in_data;
            end
        end
    endgenerate

    // A stalled output must present the same beat until it is taken
    a_out_stable: assert property (@(posedge clk) disable iff (reset_n)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

/* hw/rx_tlp_splitter.sv */
/*
 * Splits the inband header off each TLP and realigns the payload
 * to the full bus width. Tracks the packet boundary and flags beats
 * whose SOP does not match it.
 */
module rx_tlp_splitter (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  tlp_types_pkg::rx_beat_t in_beat,
    output logic                    hdr_valid,
    input  logic                    hdr_ready,
    output tlp_types_pkg::hdr_beat_t hdr_beat,
    output logic                    data_valid,
    input  logic                    data_ready,
    output tlp_types_pkg::data_beat_t data_beat,
    output logic                    hdr_event,
    output logic                    data_event,
    output logic                    frame_error
);

    import tlp_cfg_pkg::*;
    import tlp_types_pkg::*;

    logic                  process_msg;
    logic                  is_short;
    logic                  is_pure_data;
    logic [HALF_WIDTH-1:0] prev_high;
    frame_state_e          frame_state;

    // ==========================================================
    // Flow control
    // ==========================================================

    // Both outputs must have room, since one input beat may feed both
    assign in_ready = hdr_ready && data_ready;
    assign process_msg = in_valid && in_ready;

    // SOP and last together means the payload fits in the header beat
    assign is_short = in_beat.sop && in_beat.last;
    assign is_pure_data = !in_beat.sop;

    // ==========================================================
    // Header and data outputs
    // ==========================================================

    // The header sits in the low half of the SOP beat
    assign hdr_valid = process_msg && in_beat.sop;
    assign hdr_beat.hdr = tlp_hdr_t'(in_beat.data[HDR_WIDTH-1:0]);
    assign hdr_beat.dm_mode = in_beat.dm_mode;

    // Zero-length packets still push one data beat, keeping the consumer simple
    assign data_valid = process_msg && (is_pure_data || is_short);

    always_comb
    begin
        data_beat.last = in_beat.last;
        if (is_short)
        begin
            // Payload moves down into the low half, upper half is empty
            data_beat.data = {{HALF_WIDTH{1'b0}}, in_beat.data[HALF_WIDTH +: HALF_WIDTH]};
        end
        else
        begin
            // Low half from the previous beat, high half from this one
            data_beat.data = {in_beat.data[0 +: HALF_WIDTH], prev_high};
        end
    end

    // Only the upper half of a beat is ever carried forward
    always_ff @(posedge clk)
    begin
        if (process_msg)
            prev_high <= in_beat.data[HALF_WIDTH +: HALF_WIDTH];
    end

    // ==========================================================
    // Framing check
    // ==========================================================

    // A beat with last closes the packet, anything else keeps it open
    always_ff @(posedge clk)
    begin
        if (reset_n)
            frame_state <= EXPECT_SOP;
        else if (process_msg)
            frame_state <= in_beat.last ? EXPECT_SOP : IN_PACKET;
    end

    // Mismatched beats are still handled by their own SOP flag
    assign frame_error = process_msg && (in_beat.sop != (frame_state == EXPECT_SOP));

    // Outputs only fire together with a transfer, so they double as event pulses
    assign hdr_event = hdr_valid;
    assign data_event = data_valid;

endmodule

/* hw/rx_tlp_aligner.sv */
/*
 * TLP receive aligner. Wraps the header/data splitter with an entry
 * skid buffer, a header exit skid buffer and a data exit register.
 */
module rx_tlp_aligner (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  tlp_types_pkg::rx_beat_t   in_beat,
    output logic                      hdr_valid,
    input  logic                      hdr_ready,
    output tlp_types_pkg::hdr_beat_t  hdr_beat,
    output logic                      data_valid,
    input  logic                      data_ready,
    output tlp_types_pkg::data_beat_t data_beat,
    output logic                      hdr_event,
    output logic                      data_event,
    output logic                      frame_error
);

    import tlp_types_pkg::*;

    // Entry buffer to splitter
    logic       skid_valid;
    logic       skid_ready;
    rx_beat_t   skid_beat;

    // Splitter to exit buffers
    logic       split_hdr_valid;
    logic       split_hdr_ready;
    hdr_beat_t  split_hdr_beat;
    logic       split_data_valid;
    logic       split_data_ready;
    data_beat_t split_data_beat;

    // ==========================================================
    // Entry skid buffer breaks the ready path back to the source
    // ==========================================================
    stream_buffer #(.SKID(1'b1), .T(rx_beat_t)) entry_skid (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_beat),
        .out_valid (skid_valid),
        .out_ready (skid_ready),
        .out_data  (skid_beat)
    );

    rx_tlp_splitter splitter0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (skid_valid),
        .in_ready    (skid_ready),
        .in_beat     (skid_beat),
        .hdr_valid   (split_hdr_valid),
        .hdr_ready   (split_hdr_ready),
        .hdr_beat    (split_hdr_beat),
        .data_valid  (split_data_valid),
        .data_ready  (split_data_ready),
        .data_beat   (split_data_beat),
        .hdr_event   (hdr_event),
        .data_event  (data_event),
        .frame_error (frame_error)
    );

    // ==========================================================
    // Exit buffers
    // ==========================================================

    // Headers can run ahead of their payload, so this one needs two entries
    // or a consumer waiting on data would deadlock
    stream_buffer #(.SKID(1'b1), .T(hdr_beat_t)) exit_hdr_skid (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (split_hdr_valid),
        .in_ready  (split_hdr_ready),
        .in_data   (split_hdr_beat),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready),
        .out_data  (hdr_beat)
    );

    // Data side only needs a single register, which is cheaper
    stream_buffer #(.SKID(1'b0), .T(data_beat_t)) exit_data_reg (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (split_data_valid),
        .in_ready  (split_data_ready),
        .in_data   (split_data_beat),
        .out_valid (data_valid),
        .out_ready (data_ready),
        .out_data  (data_beat)
    );

endmodule

/* hw/rx_stats_regs.sv */
/*
 * Receive statistics registers. Saturating counters for headers,
 * data beats and framing errors, read and cleared by software.
 */
module rx_stats_regs (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  hdr_event,
    input  logic                                  data_event,
    input  logic                                  frame_error,
    input  logic                                  reg_rd,
    input  logic                                  reg_clr,
    input  logic [tlp_cfg_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
    output logic [tlp_cfg_pkg::CNT_WIDTH-1:0]      reg_rdata,
    output logic                                  reg_rdata_valid
);

    import tlp_cfg_pkg::*;

    // Counter index follows the register address
    logic [CNT_WIDTH-1:0] cnt [3];
    logic [2:0]           events;

    assign events = {frame_error, data_event, hdr_event};

    // Clear takes priority, otherwise count up and stick at all ones
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
        begin
            if (reset_n || reg_clr)
                cnt[i] <= '0;
            else if (events[i] && (cnt[i] != '1))
                cnt[i] <= cnt[i] + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_n)
            reg_rdata_valid <= 1'b0;
        else
            reg_rdata_valid <= reg_rd;
    end

    // Read data, held until the next read. Address 3 is unmapped
    always_ff @(posedge clk)
    begin
        if (reg_rd)
        begin
            case (reg_addr)
                REG_HDR_COUNT:  reg_rdata <= cnt[0];
                REG_DATA_COUNT: reg_rdata <= cnt[1];
                REG_ERR_COUNT:  reg_rdata <= cnt[2];
                default:        reg_rdata <= '0;
            endcase
        end
    end

    // Software never reads and clears in the same cycle
    a_rd_clr_exclusive: assert property (@(posedge clk) disable iff (reset_n)
        !(reg_rd && reg_clr));

endmodule

/* hw/rx_tlp_top.sv */
/*
 * Top of the TLP receive path. Joins the aligner to the
 * statistics register block.
 */
module rx_tlp_top (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  tlp_types_pkg::rx_beat_t               in_beat,
    output logic                                  hdr_valid,
    input  logic                                  hdr_ready,
    output tlp_types_pkg::hdr_beat_t              hdr_beat,
    output logic                                  data_valid,
    input  logic                                  data_ready,
    output tlp_types_pkg::data_beat_t             data_beat,
    input  logic                                  reg_rd,
    input  logic                                  reg_clr,
    input  logic [tlp_cfg_pkg::REG_ADDR_WIDTH-1:0] reg_addr,
    output logic [tlp_cfg_pkg::CNT_WIDTH-1:0]      reg_rdata,
    output logic                                  reg_rdata_valid
);

    // Event pulses from the splitter into the counters
    logic hdr_event;
    logic data_event;
    logic frame_error;

    rx_tlp_aligner aligner0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_beat     (in_beat),
        .hdr_valid   (hdr_valid),
        .hdr_ready   (hdr_ready),
        .hdr_beat    (hdr_beat),
        .data_valid  (data_valid),
        .data_ready  (data_ready),
        .data_beat   (data_beat),
        .hdr_event   (hdr_event),
        .data_event  (data_event),
        .frame_error (frame_error)
    );

    rx_stats_regs stats0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .hdr_event       (hdr_event),
        .data_event      (data_event),
        .frame_error     (frame_error),
        .reg_rd          (reg_rd),
        .reg_clr         (reg_clr),
        .reg_addr        (reg_addr),
        .reg_rdata       (reg_rdata),
        .reg_rdata_valid (reg_rdata_valid)
    );

endmodule

/* verif/rx_tlp_tb.sv */
/*
 * Testbench for the TLP receive path. A reference model predicts
 * headers, realigned data beats and counter values, and concurrent
 * assertions compare every output transfer against it.
 */
module rx_tlp_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import tlp_cfg_pkg::*;
    import tlp_types_pkg::*;

    // Upper bound on input beats over all tests, sizes the watchdog
    localparam int MAX_BEATS = 220;
    localparam int WATCHDOG_CYCLES = 200 * MAX_BEATS + 1000;

    logic                      clk;
    logic                      reset_n;
    logic                      in_valid;
    logic                      in_ready;
    rx_beat_t                  in_beat;
    logic                      hdr_valid;
    logic                      hdr_ready;
    hdr_beat_t                 hdr_beat;
    logic                      data_valid;
    logic                      data_ready;
    data_beat_t                data_beat;
    logic                      reg_rd;
    logic                      reg_clr;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [CNT_WIDTH-1:0]      reg_rdata;
    logic                      reg_rdata_valid;

    // Reference model state
    hdr_beat_t             exp_hdr_q[$];
    data_beat_t            exp_data_q[$];
    logic [HALF_WIDTH-1:0] model_prev_high;
    logic                  model_expect_sop;
    logic [CNT_WIDTH-1:0]  model_hdr_cnt;
    logic [CNT_WIDTH-1:0]  model_data_cnt;
    logic [CNT_WIDTH-1:0]  model_err_cnt;

    // Expected value for the transfer on the coming clock edge
    hdr_beat_t             exp_hdr;
    data_beat_t            exp_data;
    logic                  hdr_extra;
    logic                  data_extra;
    logic [CNT_WIDTH-1:0]  exp_rdata;
    logic                  rst_window;
    logic                  reset_n_last = 1'b0;

    string                 test_name;
    int                    errors;
    int                    tests;
    logic                  rand_ready;
    logic                  rand_valid;
    tlp_opcode_e           ops[4] = '{OP_MRD, OP_MWR, OP_CPL, OP_CPLD};

    rx_tlp_top dut0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_beat         (in_beat),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .hdr_beat        (hdr_beat),
        .data_valid      (data_valid),
        .data_ready      (data_ready),
        .data_beat       (data_beat),
        .reg_rd          (reg_rd),
        .reg_clr         (reg_clr),
        .reg_addr        (reg_addr),
        .reg_rdata       (reg_rdata),
        .reg_rdata_valid (reg_rdata_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================
    // Reference model and transfer monitor
    // ==========================================================

    // Applies the split and realign rules to one accepted input beat
    task automatic model_accept(input rx_beat_t b);
        hdr_beat_t  h;
        data_beat_t d;
        if (b.sop != model_expect_sop)
            model_err_cnt++;
        model_expect_sop = b.last;
        if (b.sop)
        begin
            h.hdr = tlp_hdr_t'(b.data[HDR_WIDTH-1:0]);
            h.dm_mode = b.dm_mode;
            exp_hdr_q.push_back(h);
            model_hdr_cnt++;
        end
        if (!b.sop || b.last)
        begin
            d.last = b.last;
            if (b.sop)
                d.data = {{HALF_WIDTH{1'b0}}, b.data[TDATA_WIDTH-1:HALF_WIDTH]};
            else
                d.data = {b.data[HALF_WIDTH-1:0], model_prev_high};
            exp_data_q.push_back(d);
            model_data_cnt++;
        end
        model_prev_high = b.data[TDATA_WIDTH-1:HALF_WIDTH];
    endtask

    // Signals are stable at the falling edge, so transfers due on the
    // next rising edge are known here
    always @(negedge clk)
    begin
        rst_window = reset_n || reset_n_last;
        reset_n_last = reset_n;
        if (!reset_n)
        begin
            if (in_valid && in_ready)
                model_accept(in_beat);
            if (hdr_valid && hdr_ready)
            begin
                hdr_extra = (exp_hdr_q.size() == 0);
                if (!hdr_extra)
                    exp_hdr = exp_hdr_q.pop_front();
            end
            if (data_valid && data_ready)
            begin
                data_extra = (exp_data_q.size() == 0);
                if (!data_extra)
                    exp_data = exp_data_q.pop_front();
            end
        end
    end

    // ==========================================================
    // Checking assertions
    // ==========================================================
    a_reset_quiet: assert property (@(posedge clk)
        rst_window |-> !hdr_valid && !data_valid && !reg_rdata_valid)
        else begin
            $display("Test %s: an output valid was high during or right after reset", test_name);
            errors++;
        end

    a_hdr_match: assert property (@(posedge clk) disable iff (reset_n)
        hdr_valid && hdr_ready |-> !hdr_extra && hdr_beat == exp_hdr)
        else begin
            if (hdr_extra)
                $display("Test %s: a header came out that was never expected", test_name);
            else
                $display("Fail %s: header expected %h actual %h", test_name, exp_hdr, hdr_beat);
            errors++;
        end

    a_data_match: assert property (@(posedge clk) disable iff (reset_n)
        data_valid && data_ready |-> !data_extra && data_beat == exp_data)
        else begin
            if (data_extra)
                $display("Test %s: a data beat came out that was never expected", test_name);
            else
                $display("Fail %s: data expected %h actual %h", test_name, exp_data, data_beat);
            errors++;
        end

    // Stalled outputs hold their payload
    a_hdr_hold: assert property (@(posedge clk) disable iff (reset_n)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr_beat))
        else begin
            $display("Test %s: header stream changed while stalled", test_name);
            errors++;
        end

    a_data_hold: assert property (@(posedge clk) disable iff (reset_n)
        data_valid && !data_ready |=> data_valid && $stable(data_beat))
        else begin
            $display("Test %s: data stream changed while stalled", test_name);
            errors++;
        end

    a_reg_match: assert property (@(posedge clk) disable iff (reset_n)
        reg_rdata_valid |-> reg_rdata == exp_rdata)
        else begin
            $display("Fail %s: register expected %h actual %h", test_name, exp_rdata, reg_rdata);
            errors++;
        end

    // ==========================================================
    // Stimulus helpers
    // ==========================================================

    // Output ready, random when the test asks for back-pressure
    always @(posedge clk)
    begin
        #1;
        hdr_ready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
        data_ready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    function automatic rx_beat_t make_beat(input logic sop, input logic last);
        rx_beat_t b;
        b.data = {$urandom, $urandom, $urandom, $urandom};
        b.sop = sop;
        b.last = last;
        b.dm_mode = $urandom_range(0, 1);
        return b;
    endfunction

    // Tasks start and end 1 ns after a rising edge
    task automatic send_beat(input rx_beat_t b);
        logic taken;
        in_valid = 1'b0;
        repeat (rand_valid ? $urandom_range(0, 2) : 0)
        begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_beat = b;
        do
        begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        while (!taken);
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int nbeats, input tlp_opcode_e op);
        rx_beat_t b;
        tlp_hdr_t h;
        h = tlp_hdr_t'({$urandom, $urandom});
        h.opcode = op;
        b = make_beat(1'b1, nbeats == 1);
        b.data[HDR_WIDTH-1:0] = h;
        send_beat(b);
        for (int i = 1; i < nbeats; i++)
            send_beat(make_beat(1'b0, i == nbeats - 1));
    endtask

    // Waits until every predicted output has come out
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_hdr_q.size() != 0 || exp_data_q.size() != 0) && n < 1000)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (exp_hdr_q.size() == 0 && exp_data_q.size() == 0)
        else begin
            $display("Test %s: %0d headers and %0d data beats never came out",
                     test_name, exp_hdr_q.size(), exp_data_q.size());
            errors++;
        end
        // Last transfer edge plus the one-cycle counter update
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_reg(input logic [REG_ADDR_WIDTH-1:0] addr,
                            input logic [CNT_WIDTH-1:0] expected);
        int n;
        exp_rdata = expected;
        reg_addr = addr;
        reg_rd = 1'b1;
        @(posedge clk);
        #1;
        reg_rd = 1'b0;
        n = 0;
        while (!reg_rdata_valid && n < 20)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!reg_rdata_valid)
        begin
            $display("Test %s: register read at address %0d got no response", test_name, addr);
            errors++;
        end
        // Let the check sample the response before the next read moves on
        @(posedge clk);
        #1;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s done, %0d errors so far", test_name, errors);
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial
    begin
        void'($urandom(32'h15c5));
        errors = 0;
        tests = 0;
        rand_ready = 1'b0;
        rand_valid = 1'b0;
        reset_n = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        hdr_ready = 1'b1;
        data_ready = 1'b1;
        reg_rd = 1'b0;
        reg_clr = 1'b0;
        reg_addr = '0;
        exp_rdata = '0;
        hdr_extra = 1'b0;
        data_extra = 1'b0;
        rst_window = 1'b0;
        model_expect_sop = 1'b1;
        model_hdr_cnt = '0;
        model_data_cnt = '0;
        model_err_cnt = '0;
        test_name = "reset";

        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b0;
        repeat (2)
        begin
            @(posedge clk);
            #1;
        end
        end_test();

        test_name = "short_packets";
        for (int i = 0; i < 8; i++)
            send_packet(1, ops[i % 4]);
        wait_drain();
        end_test();

        test_name = "multi_beat";
        repeat (10) send_packet($urandom_range(2, 6), ops[$urandom_range(0, 3)]);
        wait_drain();
        end_test();

        test_name = "back_pressure";
        rand_ready = 1'b1;
        rand_valid = 1'b1;
        repeat (20) send_packet($urandom_range(1, 6), ops[$urandom_range(0, 3)]);
        wait_drain();
        rand_ready = 1'b0;
        rand_valid = 1'b0;
        end_test();

        // SOP inside a packet, then a data beat after the packet closed
        test_name = "framing_error";
        send_beat(make_beat(1'b1, 1'b0));
        send_beat(make_beat(1'b0, 1'b0));
        send_beat(make_beat(1'b1, 1'b0));
        send_beat(make_beat(1'b0, 1'b1));
        send_beat(make_beat(1'b0, 1'b1));
        send_packet(1, OP_MRD);
        wait_drain();
        read_reg(REG_ERR_COUNT, model_err_cnt);
        read_reg(REG_HDR_COUNT, model_hdr_cnt);
        read_reg(REG_DATA_COUNT, model_data_cnt);
        end_test();

        // All three counters are nonzero here, so the clear touches each one
        test_name = "counters";
        send_packet(1, OP_CPL);
        send_packet(3, OP_MWR);
        send_packet(2, OP_CPLD);
        wait_drain();
        read_reg(REG_HDR_COUNT, model_hdr_cnt);
        read_reg(REG_DATA_COUNT, model_data_cnt);
        read_reg(REG_ERR_COUNT, model_err_cnt);
        reg_clr = 1'b1;
        @(posedge clk);
        #1;
        reg_clr = 1'b0;
        model_hdr_cnt = '0;
        model_data_cnt = '0;
        model_err_cnt = '0;
        read_reg(REG_HDR_COUNT, '0);
        read_reg(REG_DATA_COUNT, '0);
        read_reg(REG_ERR_COUNT, '0);
        end_test();

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // Ends a stuck run
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* rx_tlp.f */
hw/tlp_cfg_pkg.sv
hw/tlp_types_pkg.sv
hw/stream_buffer.sv
hw/rx_tlp_splitter.sv
hw/rx_tlp_aligner.sv
hw/rx_stats_regs.sv
hw/rx_tlp_top.sv
verif/rx_tlp_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the TLP receive path testbench with Verilator, runs it and
# checks the log for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rx_tlp_tb \
    -f rx_tlp.f --Mdir obj_dir -o rx_tlp_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rx_tlp_sim > sim.log 2>&1 ; cat sim.log

grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
